// File: host_bridge.f
+incdir+tb
hdl/host_bridge_pkg.sv
hdl/msg_fifo.sv
hdl/wb_decode.sv
hdl/wb_execute.sv
hdl/wb_result.sv
hdl/host_bridge.sv
tb/host_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the host_bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module host_bridge_tb \
  -f host_bridge.f \
  --Mdir "$BUILD_DIR" -o host_bridge_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$BUILD_DIR/host_bridge_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  exit 0
fi
exit 1

// File: tb/host_bridge_model.svh
`ifndef HOST_BRIDGE_MODEL_SVH
`define HOST_BRIDGE_MODEL_SVH

// Reference queues for the PC, FPGA and loopback FIFOs
msg_t pc_q[$];
msg_t fpga_q[$];
msg_t loop_q[$];
logic model_done;
logic model_overflow;

function automatic void reset_model();
  pc_q.delete();
  fpga_q.delete();
  loop_q.delete();
  model_done = 1'b0;
  model_overflow = 1'b0;
endfunction

// Effect of one request at its start edge
// Gives back the response word
function automatic msg_t bus_response(input logic we, input logic [1:0] adr, input msg_t dat);
  msg_t    rsp;
  status_t st;
  rsp = '0;
  st = '0;
  if (!we && adr == 2'd0) begin
    if (pc_q.size() > 0) begin
      rsp = pc_q.pop_front();
      // Copy only when the loopback queue has room
      if (loop_q.size() < Q_DEPTH) begin
        loop_q.push_back(rsp);
      end
    end
  end else if (we && adr == 2'd1) begin
    rsp = dat;
    if (rd_open && fpga_q.size() < Q_DEPTH) begin
      fpga_q.push_back(dat);
    end else if (rd_open) begin
      model_overflow = 1'b1;
    end
  end else if (!we && adr == 2'd2) begin
    st.pc_empty = (pc_q.size() == 0);
    st.fpga_full = (fpga_q.size() == Q_DEPTH);
    st.overflow = model_overflow;
    st.done = model_done;
    rsp = st;
  end else if (we && adr == 2'd3) begin
    model_done = 1'b1;
  end
  return rsp;
endfunction

function automatic logic rd_eof_rule();
  return model_done || (pc_q.size() > 0 && pc_q[0] == END_MARKER && fpga_q.size() == 0);
endfunction

function automatic logic loop_eof_rule();
  return !wr_open && loop_q.size() == 0;
endfunction

`endif

// File: tb/host_bridge_tb.sv
`default_nettype none

module host_bridge_tb import host_bridge_pkg::*; ();

  localparam int FIFO_AW = 4;
  localparam int Q_DEPTH = 1 << FIFO_AW;
  localparam int ACK_TIMEOUT = 8;
  localparam int FLAG_TIMEOUT = 200;

  logic    bus_clk;
  logic    rst;
  logic    wr_wren;
  msg_t    wr_data;
  logic    wr_open;
  logic    rd_rden;
  logic    rd_open;
  logic    loop_rden;
  wb_req_t wb_req;
  logic    wr_full;
  msg_t    rd_data;
  logic    rd_empty;
  logic    rd_eof;
  msg_t    loop_data;
  logic    loop_empty;
  logic    loop_eof;
  wb_rsp_t wb_rsp;

  logic    bus_start;
  logic    host_traffic;
  msg_t    exp_rsp;

  `include "host_bridge_model.svh"

  host_bridge #(.FIFO_AW(FIFO_AW)) dut_i (
    .bus_clk    (bus_clk),
    .rst        (rst),
    .wr_wren    (wr_wren),
    .wr_data    (wr_data),
    .wr_open    (wr_open),
    .rd_rden    (rd_rden),
    .rd_open    (rd_open),
    .loop_rden  (loop_rden),
    .wb_req     (wb_req),
    .wr_full    (wr_full),
    .rd_data    (rd_data),
    .rd_empty   (rd_empty),
    .rd_eof     (rd_eof),
    .loop_data  (loop_data),
    .loop_empty (loop_empty),
    .loop_eof   (loop_eof),
    .wb_rsp     (wb_rsp)
  );

  initial begin
    bus_clk = 1'b0;
    forever #4 bus_clk = ~bus_clk;
  end

  // ******************************
  // Checks
  // ******************************

  task automatic check_value(input string name, input msg_t got, input msg_t exp);
    assert (got === exp) else begin
      $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at t=%0t: %s", $time, what);
    $display("Regression failed");
    $fatal(1, "wait limit reached");
  endtask

  task automatic drive_random_host();
    wr_wren = ($urandom_range(1, 0) == 0);
    wr_data = $urandom();
    rd_rden = ($urandom_range(3, 0) == 0);
    loop_rden = ($urandom_range(3, 0) == 0);
    if ($urandom_range(15, 0) == 0) begin
      rd_open = ~rd_open;
    end
  endtask

  // One clock of model update before the edge
  // Compare at the falling edge after it
  task automatic next_cycle();
    logic exp_rd_eof;
    logic exp_loop_eof;
    logic exp_ack;
    logic wr_ok;
    logic rd_ok;
    logic loop_ok;
    exp_rd_eof = rd_eof_rule();
    exp_loop_eof = loop_eof_rule();
    exp_ack = bus_start;
    wr_ok = wr_wren && pc_q.size() < Q_DEPTH;
    rd_ok = rd_rden && fpga_q.size() > 0;
    loop_ok = loop_rden && loop_q.size() > 0;
    // Bus operation sees the queues as they were before the edge
    if (bus_start) begin
      exp_rsp = bus_response(wb_req.we, wb_req.adr, wb_req.dat);
      bus_start = 1'b0;
    end
    if (rd_ok) begin
      fpga_q.delete(0);
    end
    if (loop_ok) begin
      loop_q.delete(0);
    end
    if (wr_ok) begin
      pc_q.push_back(wr_data);
    end
    @(negedge bus_clk);
    check_flag("rd_eof", rd_eof, exp_rd_eof);
    check_flag("loop_eof", loop_eof, exp_loop_eof);
    check_flag("wb_rsp.ack", wb_rsp.ack, exp_ack);
    if (exp_ack) begin
      check_value("wb_rsp.dat", wb_rsp.dat, exp_rsp);
    end
    check_flag("wr_full", wr_full, pc_q.size() == Q_DEPTH);
    check_flag("rd_empty", rd_empty, fpga_q.size() == 0);
    check_flag("loop_empty", loop_empty, loop_q.size() == 0);
    if (fpga_q.size() > 0) begin
      check_value("rd_data", rd_data, fpga_q[0]);
    end
    if (loop_q.size() > 0) begin
      check_value("loop_data", loop_data, loop_q[0]);
    end
    if (host_traffic) begin
      drive_random_host();
    end
  endtask

  // ******************************
  // Bus and stream helpers
  // ******************************

  task automatic bus_transfer(input logic we, input logic [1:0] adr, input msg_t dat,
                              output msg_t rdata);
    int waited;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    bus_start = 1'b1;
    waited = 0;
    do begin
      next_cycle();
      waited++;
    end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
    if (!wb_rsp.ack) begin
      stop_on_timeout("Wishbone ack never arrived");
    end
    rdata = wb_rsp.dat;
    wb_req = '0;
    // Ack must drop after one cycle
    next_cycle();
  endtask

  task automatic drain_stream(input logic loop_side);
    int n;
    n = 0;
    while (!(loop_side ? loop_empty : rd_empty) && n < FLAG_TIMEOUT) begin
      if (loop_side) begin
        loop_rden = 1'($urandom_range(1, 0));
      end else begin
        rd_rden = 1'($urandom_range(1, 0));
      end
      next_cycle();
      n++;
    end
    loop_rden = 1'b0;
    rd_rden = 1'b0;
    if (!(loop_side ? loop_empty : rd_empty)) begin
      stop_on_timeout("host stream did not drain");
    end
  endtask

  task automatic wait_eof(input logic loop_side);
    int n;
    n = 0;
    while (!(loop_side ? loop_eof : rd_eof) && n < FLAG_TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (!(loop_side ? loop_eof : rd_eof)) begin
      stop_on_timeout("end-of-file flag never rose");
    end
  endtask

  // ******************************
  // Stimulus
  // ******************************

  initial begin
    msg_t       rdata;
    int         n;
    int         k;
    int         idle;
    logic       op_we;
    logic [1:0] op_adr;
    rst = 1'b1;
    wr_wren = 1'b0;
    wr_data = '0;
    wr_open = 1'b1;
    rd_rden = 1'b0;
    rd_open = 1'b1;
    loop_rden = 1'b0;
    wb_req = '0;
    bus_start = 1'b0;
    host_traffic = 1'b0;
    exp_rsp = '0;
    void'($urandom(32'h36a333b8));
    reset_model();
    repeat (3) @(negedge bus_clk);
    rst = 1'b0;
    next_cycle();

    bus_transfer(1'b0, 2'd2, '0, rdata);
    check_value("status after reset", rdata, 32'h1);

    // Overfill the PC queue, then pop past empty
    for (n = 0; n < 20; n++) begin
      wr_wren = 1'b1;
      wr_data = $urandom();
      next_cycle();
    end
    wr_wren = 1'b0;
    for (n = 0; n < 20; n++) begin
      bus_transfer(1'b0, 2'd0, '0, rdata);
    end
    // Copies dropped with the loopback queue full
    for (n = 0; n < 6; n++) begin
      wr_wren = 1'b1;
      wr_data = $urandom();
      next_cycle();
    end
    wr_wren = 1'b0;
    for (n = 0; n < 6; n++) begin
      bus_transfer(1'b0, 2'd0, '0, rdata);
    end
    drain_stream(1'b1);

    // FPGA pushes past full, then with the read stream closed
    for (n = 0; n < 18; n++) begin
      bus_transfer(1'b1, 2'd1, $urandom(), rdata);
    end
    bus_transfer(1'b0, 2'd2, '0, rdata);
    check_flag("status.overflow", rdata[2], 1'b1);
    drain_stream(1'b0);
    rd_open = 1'b0;
    for (n = 0; n < 3; n++) begin
      bus_transfer(1'b1, 2'd1, $urandom(), rdata);
    end
    rd_open = 1'b1;

    // Wrong direction for the address
    bus_transfer(1'b0, 2'd1, '0, rdata);
    bus_transfer(1'b1, 2'd0, $urandom(), rdata);
    bus_transfer(1'b0, 2'd3, '0, rdata);
    bus_transfer(1'b1, 2'd2, $urandom(), rdata);

    // Random host traffic mixed with random requests
    host_traffic = 1'b1;
    drive_random_host();
    for (n = 0; n < 300; n++) begin
      op_we = 1'($urandom_range(1, 0));
      op_adr = 2'($urandom_range(3, 0));
      // Done stays clear until the end-of-file phase
      if (op_we && op_adr == 2'd3) begin
        op_adr = 2'd1;
      end
      bus_transfer(op_we, op_adr, $urandom(), rdata);
      idle = $urandom_range(2, 0);
      for (k = 0; k < idle; k++) begin
        next_cycle();
      end
    end
    host_traffic = 1'b0;
    wr_wren = 1'b0;
    rd_rden = 1'b0;
    loop_rden = 1'b0;
    rd_open = 1'b1;
    n = 0;
    while (pc_q.size() > 0 && n < 2 * Q_DEPTH) begin
      bus_transfer(1'b0, 2'd0, '0, rdata);
      n++;
    end
    drain_stream(1'b0);
    drain_stream(1'b1);

    // End marker at the PC head with an empty read queue
    wr_wren = 1'b1;
    wr_data = END_MARKER;
    next_cycle();
    wr_wren = 1'b0;
    wait_eof(1'b0);
    bus_transfer(1'b0, 2'd0, '0, rdata);
    bus_transfer(1'b1, 2'd3, '0, rdata);
    wait_eof(1'b0);
    wr_open = 1'b0;
    drain_stream(1'b1);
    wait_eof(1'b1);

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/host_bridge.sv
`default_nettype none

module host_bridge import host_bridge_pkg::*; #(
  parameter int FIFO_AW = 4
) (
  input  wire logic    bus_clk,
  input  wire logic    rst,
  input  wire logic    wr_wren,
  input  wire msg_t    wr_data,
  input  wire logic    wr_open,
  input  wire logic    rd_rden,
  input  wire logic    rd_open,
  input  wire logic    loop_rden,
  input  wire wb_req_t wb_req,
  output logic         wr_full,
  output msg_t         rd_data,
  output logic         rd_empty,
  output logic         rd_eof,
  output msg_t         loop_data,
  output logic         loop_empty,
  output logic         loop_eof,
  output wb_rsp_t      wb_rsp
);

  wb_op_e op;
  logic   start;
  msg_t   resp_dat;
  logic   done;

  msg_t   pc_head;
  logic   pc_empty;
  logic   pc_pop;
  logic   fpga_full;
  logic   fpga_push;
  logic   loop_full;
  logic   loop_push;

  // ******************************
  // Message queues
  // ******************************

  // Host write stream into the application
  msg_fifo #(.FIFO_AW(FIFO_AW)) pc_fifo_i (
    .bus_clk   (bus_clk),
    .rst       (rst),
    .push      (wr_wren),
    .push_data (wr_data),
    .pop       (pc_pop),
    .head      (pc_head),
    .empty     (pc_empty),
    .full      (wr_full)
  );

  // Application words out to the host read stream
  msg_fifo #(.FIFO_AW(FIFO_AW)) fpga_fifo_i (
    .bus_clk   (bus_clk),
    .rst       (rst),
    .push      (fpga_push),
    .push_data (wb_req.dat),
    .pop       (rd_rden),
    .head      (rd_data),
    .empty     (rd_empty),
    .full      (fpga_full)
  );

  // Copies of consumed PC words
  msg_fifo #(.FIFO_AW(FIFO_AW)) loop_fifo_i (
    .bus_clk   (bus_clk),
    .rst       (rst),
    .push      (loop_push),
    .push_data (pc_head),
    .pop       (loop_rden),
    .head      (loop_data),
    .empty     (loop_empty),
    .full      (loop_full)
  );

  // ******************************
  // Wishbone slave
  // ******************************

  wb_decode wb_decode_i (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wb_req  (wb_req),
    .ack     (wb_rsp.ack),
    .op      (op),
    .start   (start)
  );

  wb_execute wb_execute_i (
    .bus_clk   (bus_clk),
    .rst       (rst),
    .op        (op),
    .start     (start),
    .wr_dat    (wb_req.dat),
    .rd_open   (rd_open),
    .pc_head   (pc_head),
    .pc_empty  (pc_empty),
    .fpga_full (fpga_full),
    .loop_full (loop_full),
    .pc_pop    (pc_pop),
    .fpga_push (fpga_push),
    .loop_push (loop_push),
    .resp_dat  (resp_dat),
    .done      (done)
  );

  wb_result wb_result_i (
    .bus_clk    (bus_clk),
    .rst        (rst),
    .start      (start),
    .resp_dat   (resp_dat),
    .done       (done),
    .pc_head    (pc_head),
    .pc_empty   (pc_empty),
    .rd_empty   (rd_empty),
    .wr_open    (wr_open),
    .loop_empty (loop_empty),
    .wb_rsp     (wb_rsp),
    .rd_eof     (rd_eof),
    .loop_eof   (loop_eof)
  );

endmodule

`default_nettype wire

// File: hdl/wb_result.sv
`default_nettype none

module wb_result import host_bridge_pkg::*; (
  input  wire logic bus_clk,
  input  wire logic rst,
  input  wire logic start,
  input  wire msg_t resp_dat,
  input  wire logic done,
  input  wire msg_t pc_head,
  input  wire logic pc_empty,
  input  wire logic rd_empty,
  input  wire logic wr_open,
  input  wire logic loop_empty,
  output wb_rsp_t   wb_rsp,
  output logic      rd_eof,
  output logic      loop_eof
);

  logic end_seen;

  // End marker at the head of the PC queue
  assign end_seen = !pc_empty && (pc_head == END_MARKER);

  // ******************************
  // Wishbone response
  // ******************************

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wb_rsp.ack <= 1'b0;
    end else begin
      wb_rsp.ack <= start;
    end
  end

  // Valid only alongside ack
  always_ff @(posedge bus_clk) begin
    if (start) begin
      wb_rsp.dat <= resp_dat;
    end
  end

  // ******************************
  // End-of-file flags
  // ******************************

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      rd_eof   <= 1'b0;
      loop_eof <= 1'b0;
    end else begin
      rd_eof   <= done || (end_seen && rd_empty);
      // Host closed the write side and the copies are drained
      loop_eof <= !wr_open && loop_empty;
    end
  end

  // Single-cycle acknowledge per request
  assert property (@(posedge bus_clk) disable iff (rst)
    wb_rsp.ack |=> !wb_rsp.ack)
    else $error("wb_result ack held for more than one cycle");

endmodule

`default_nettype wire

// File: hdl/wb_execute.sv
`default_nettype none

module wb_execute import host_bridge_pkg::*; (
  input  wire logic   bus_clk,
  input  wire logic   rst,
  input  wire wb_op_e op,
  input  wire logic   start,
  input  wire msg_t   wr_dat,
  input  wire logic   rd_open,
  input  wire msg_t   pc_head,
  input  wire logic   pc_empty,
  input  wire logic   fpga_full,
  input  wire logic   loop_full,
  output logic        pc_pop,
  output logic        fpga_push,
  output logic        loop_push,
  output msg_t        resp_dat,
  output logic        done
);

  logic    overflow;
  status_t status;

  always_comb begin
    status           = '0;
    status.pc_empty  = pc_empty;
    status.fpga_full = fpga_full;
    status.overflow  = overflow;
    status.done      = done;
  end

  // ******************************
  // FIFO strobes and response word
  // ******************************

  always_comb begin
    pc_pop    = 1'b0;
    fpga_push = 1'b0;
    loop_push = 1'b0;
    resp_dat  = '0;
    case (op)
      OP_POP_PC: begin
        if (!pc_empty) begin
          resp_dat  = pc_head;
          pc_pop    = start;
          // Copy dropped when the loopback queue is full
          loop_push = start && !loop_full;
        end
      end
      OP_PUSH_FPGA: begin
        // Echo of the written word
        resp_dat  = wr_dat;
        fpga_push = start && rd_open && !fpga_full;
      end
      OP_STATUS: begin
        resp_dat = status;
      end
      default: begin
        resp_dat = '0;
      end
    endcase
  end

  // ******************************
  // Sticky flags
  // ******************************

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      done     <= 1'b0;
      overflow <= 1'b0;
    end else if (start) begin
      if (op == OP_SET_DONE) begin
        done <= 1'b1;
      end
      // Push refused by a full FPGA queue
      if (op == OP_PUSH_FPGA && rd_open && fpga_full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/wb_decode.sv
`default_nettype none

module wb_decode import host_bridge_pkg::*; (
  input  wire logic    bus_clk,
  input  wire logic    rst,
  input  wire wb_req_t wb_req,
  input  wire logic    ack,
  output wb_op_e       op,
  output logic         start
);

  // ******************************
  // Address map
  // ******************************

  always_comb begin
    case ({wb_req.we, wb_req.adr})
      3'b0_00: op = OP_POP_PC;
      3'b1_01: op = OP_PUSH_FPGA;
      3'b0_10: op = OP_STATUS;
      3'b1_11: op = OP_SET_DONE;
      // Wrong direction for the address
      default: op = OP_NONE;
    endcase
  end

  // Pending request not yet acknowledged
  assign start = wb_req.cyc && wb_req.stb && !ack;

  // The ack that follows a start masks the held request
  assert property (@(posedge bus_clk) disable iff (rst)
    start |=> !start)
    else $error("wb_decode start in back-to-back cycles");

endmodule

`default_nettype wire

// File: hdl/msg_fifo.sv
`default_nettype none

module msg_fifo import host_bridge_pkg::*; #(
  parameter int FIFO_AW = 4
) (
  input  wire logic bus_clk,
  input  wire logic rst,
  input  wire logic push,
  input  wire msg_t push_data,
  input  wire logic pop,
  output msg_t      head,
  output logic      empty,
  output logic      full
);

  localparam int DEPTH = 1 << FIFO_AW;

  msg_t mem [DEPTH];

  // One extra bit tells full from empty
  logic [FIFO_AW:0] wr_ptr;
  logic [FIFO_AW:0] rd_ptr;
  logic [FIFO_AW:0] count;

  logic do_push;
  logic do_pop;

  assign count = wr_ptr - rd_ptr;
  assign empty = (count == '0);
  assign full  = (count == (FIFO_AW + 1)'(DEPTH));

  // Requests against full or empty are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Show-ahead read of the oldest word
  assign head = mem[rd_ptr[FIFO_AW-1:0]];

  always_ff @(posedge bus_clk) begin
    if (do_push) begin
      mem[wr_ptr[FIFO_AW-1:0]] <= push_data;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Pointers never drift more than one lap apart
  assert property (@(posedge bus_clk) disable iff (rst)
    count <= (FIFO_AW + 1)'(DEPTH))
    else $error("msg_fifo count above depth");

endmodule

`default_nettype wire

// File: hdl/host_bridge_pkg.sv
`default_nettype none

package host_bridge_pkg;

  // ******************************
  // Message word
  // ******************************

  localparam int MSG_W = 32;

  typedef logic [MSG_W-1:0] msg_t;

  // All ones closes a PC message sequence
  localparam msg_t END_MARKER = '1;

  // ******************************
  // Wishbone operations
  // ******************************

  typedef enum logic [2:0] {
    OP_NONE,
    OP_POP_PC,
    OP_PUSH_FPGA,
    OP_STATUS,
    OP_SET_DONE
  } wb_op_e;

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [1:0] adr;
    msg_t       dat;
  } wb_req_t;

  typedef struct packed {
    logic ack;
    msg_t dat;
  } wb_rsp_t;

  // Flags in the low bits
  // Upper bits read as zero
  typedef struct packed {
    logic [MSG_W-5:0] rsvd;
    logic             done;
    logic             overflow;
    logic             fpga_full;
    logic             pc_empty;
  } status_t;

endpackage

`default_nettype wire
